//--- compile.f
+incdir+verilog
verilog/arm_pkg.sv
verilog/fetch_if.sv
verilog/if_stage.sv
verilog/if_stage_reg.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/id_stage.sv
verilog/arm_front.sv
tb/arm_front_assert.sv
tb/arm_front_tb.sv

//--- tb/arm_front_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module arm_front_assert (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_ack,
	input wire logic [`ADDRESS_LEN-1:0] wb_adr
);
	// Strobe is only legal inside a bus cycle
	stb_inside_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc)
		else $error("wb_stb high while wb_cyc is low");

	// Strobe and address hold while waiting for ack
	adr_stable_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
		else $error("wb_stb or wb_adr changed while waiting for wb_ack");

	cyc_low_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !wb_cyc)
		else $error("wb_cyc high in the first cycle after reset");
endmodule

`default_nettype wire

//--- tb/arm_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module arm_front_tb;
	logic clk;
	logic rst_n;
	logic freeze;
	logic flush;
	logic branch_taken;
	logic [`ADDRESS_LEN-1:0] branch_addr;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`ADDRESS_LEN-1:0] wb_adr;
	logic wb_ack;
	logic [`INSTRUCTION_LEN-1:0] wb_dat_i;
	logic wb_en;
	logic [`REG_ADDRESS_LEN-1:0] wb_addr;
	logic [`REGISTER_LEN-1:0] wb_data;
	logic [`ADDRESS_LEN-1:0] id_pc;
	logic id_valid;
	logic [`EXECUTE_COMMAND_LEN-1:0] id_exe_cmd;
	logic id_mem_read;
	logic id_mem_write;
	logic id_wb_en;
	logic id_immediate;
	logic id_branch_taken;
	logic id_status_write;
	logic [`REGISTER_LEN-1:0] id_reg1;
	logic [`REGISTER_LEN-1:0] id_reg2;
	logic [`REG_ADDRESS_LEN-1:0] id_dest;
	logic [`SIGNED_IMMEDIATE_LEN-1:0] id_signed_imm;
	logic [`SHIFT_OPERAND_LEN-1:0] id_shift_operand;

	logic [31:0] tdata [0:63];
	logic [31:0] prog [0:15];
	logic [31:0] exp_word [0:47];
	int prog_len = 0;
	int errors = 0;
	int checks = 0;
	integer seed = 90334;
	int lat;

	arm_front DUT (.*);

	bind arm_front arm_front_assert u_assert (
		.clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc),
		.wb_stb(wb_stb), .wb_ack(wb_ack), .wb_adr(wb_adr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Instruction memory with random ack latency driven on the falling edge
	always @(negedge clk) begin
		if (wb_ack) begin
			wb_ack <= 1'b0;
			lat = $unsigned($random(seed)) % 4;
		end else if (wb_cyc && wb_stb) begin
			if (lat == 0) begin
				check_value(wb_we, 1'b0, "wb_we during fetch");
				wb_ack <= 1'b1;
				wb_dat_i <= (wb_adr[31:2] < prog_len) ? prog[wb_adr[31:2]]
					: wb_adr ^ 32'h5A5A_5A5A;
			end else begin
				lat = lat - 1;
			end
		end
	end

	initial begin
		wait (prog_len != 0);
		repeat (prog_len * 6 + 50) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock periods",
			prog_len * 6 + 50);
		$display("TEST FAIL");
		$finish;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic wait_decode();
		do @(negedge clk); while (!id_valid);
	endtask

	// Compares the decoded item against program word k
	task automatic verify_item(input int k);
		logic [31:0] e;
		e = exp_word[k*3];
		check_value(id_pc, (k + 1) * 4, $sformatf("pc of item %0d", k));
		check_value(id_exe_cmd, e[15:12], $sformatf("exe_cmd of item %0d", k));
		check_value(id_dest, e[11:8], $sformatf("dest of item %0d", k));
		check_value({id_mem_read, id_mem_write, id_wb_en, id_immediate,
			id_branch_taken, id_status_write}, e[5:0], $sformatf("flags of item %0d", k));
		check_value(id_reg1, exp_word[k*3+1], $sformatf("reg1 of item %0d", k));
		check_value(id_reg2, exp_word[k*3+2], $sformatf("reg2 of item %0d", k));
		check_value(id_signed_imm, prog[k][23:0], $sformatf("signed_imm of item %0d", k));
		check_value(id_shift_operand, prog[k][11:0], $sformatf("shift of item %0d", k));
	endtask

	initial begin
		int n_pre;
		int p;
		int start_err;
		logic idle_seen;
		rst_n = 1'b0;
		freeze = 1'b1;
		flush = 1'b0;
		branch_taken = 1'b0;
		branch_addr = '0;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		wb_en = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		lat = $unsigned($random(seed)) % 4;
		$readmemh("tb/arm_front_testdata.txt", tdata);
		n_pre = tdata[0];
		p = 1 + n_pre * 2;
		for (int i = 0; i < tdata[p]; i++)
			prog[i] = tdata[p + 1 + i];
		for (int i = 0; i < tdata[p] * 3; i++)
			exp_word[i] = tdata[p + 1 + tdata[p] + i];
		prog_len = tdata[p];
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// Register preload through the write-back port while freeze holds the fetch
		for (int i = 0; i < n_pre; i++) begin
			@(negedge clk);
			wb_en = 1'b1;
			wb_addr = tdata[1 + i * 2];
			wb_data = tdata[2 + i * 2];
		end
		@(negedge clk);
		wb_en = 1'b0;
		freeze = 1'b0;

		start_err = errors;
		for (int k = 0; k < prog_len; k++) begin
			wait_decode();
			verify_item(k);
			if (k == 6)
				$display("Test 1 data processing decode: %0d errors", errors - start_err);
			if (k == 10)
				$display("Test 2 compare and memory decode: %0d errors", errors - start_err);
		end
		$display("Test 3 pc sequence over %0d items: %0d errors", prog_len,
			errors - start_err);

		start_err = errors;
		while (!wb_cyc) @(negedge clk);
		branch_taken = 1'b1;
		branch_addr = 32'd12;
		@(negedge clk);
		branch_taken = 1'b0;
		wait_decode();
		verify_item(3);
		wait_decode();
		verify_item(4);
		$display("Test 4 branch redirect: %0d errors", errors - start_err);

		start_err = errors;
		wait_decode();
		freeze = 1'b1;
		idle_seen = 1'b0;
		repeat (8) begin
			@(negedge clk);
			check_value(id_valid, 1'b1, "id_valid under freeze");
			verify_item(5);
			if (!wb_cyc) begin
				idle_seen = 1'b1;
			end else if (idle_seen) begin
				errors++;
				$display("Fetch bus became active again while freeze was held");
			end
		end
		check_value(idle_seen, 1'b1, "fetch bus idle under freeze");

		// The held word reaches IF/ID first and the flush then drops it
		freeze = 1'b0;
		@(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		check_value(id_valid, 1'b0, "id_valid after flush");
		$display("Test 5 freeze and flush: %0d errors", errors - start_err);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule

`default_nettype wire

//--- tb/arm_front_testdata.txt
// Preload count, then register/value pairs, then program length and program words
// Per instruction: {exe_cmd,dest,flags mr mw wb imm br st} word, then reg1, reg2
00000004
00000001 00000005 00000002 00000007 00000003 00000100 00000004 000000A5
0000000C
E0815002 E0426001 E0037004 E1818004 E0229003 E3A0A012
E1E0B004 E1510002 E31300FF E593C004 E5834008 EA000010
00002508 00000005 00000007
00004608 00000007 00000005
00006708 00000100 000000A5
00007808 00000005 000000A5
00008908 00000007 00000100
00001A0C 00000000 00000000
00009B08 00000000 000000A5
00004001 00000005 00000007
00006005 00000100 00000000
00002C28 00000100 00000000
00002410 00000100 000000A5
00000002 00000000 00000000

//--- verilog/arm_defs.svh
`ifndef ARM_DEFS_SVH
`define ARM_DEFS_SVH

// Bus and datapath widths
`define ADDRESS_LEN 32
`define INSTRUCTION_LEN 32
`define REGISTER_LEN 32

// Register file addressing, R0 to R14 are stored
`define REG_ADDRESS_LEN 4
`define REG_FILE_DEPTH 15

// Execute command handed to the EX stage
`define EXECUTE_COMMAND_LEN 4

// Instruction field widths
`define SIGNED_IMMEDIATE_LEN 24
`define SHIFT_OPERAND_LEN 12

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- verilog/arm_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module arm_front (
	input  logic clk,
	input  logic rst_n,
	input  logic freeze,
	input  logic flush,
	input  logic branch_taken,
	input  logic [`ADDRESS_LEN-1:0] branch_addr,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`ADDRESS_LEN-1:0] wb_adr,
	input  logic wb_ack,
	input  logic [`INSTRUCTION_LEN-1:0] wb_dat_i,
	input  logic wb_en,
	input  logic [`REG_ADDRESS_LEN-1:0] wb_addr,
	input  logic [`REGISTER_LEN-1:0] wb_data,
	output logic [`ADDRESS_LEN-1:0] id_pc,
	output logic id_valid,
	output logic [`EXECUTE_COMMAND_LEN-1:0] id_exe_cmd,
	output logic id_mem_read,
	output logic id_mem_write,
	output logic id_wb_en,
	output logic id_immediate,
	output logic id_branch_taken,
	output logic id_status_write,
	output logic [`REGISTER_LEN-1:0] id_reg1,
	output logic [`REGISTER_LEN-1:0] id_reg2,
	output logic [`REG_ADDRESS_LEN-1:0] id_dest,
	output logic [`SIGNED_IMMEDIATE_LEN-1:0] id_signed_imm,
	output logic [`SHIFT_OPERAND_LEN-1:0] id_shift_operand
);
	import arm_pkg::*;

	logic [`ADDRESS_LEN-1:0] if_pc;
	logic [`INSTRUCTION_LEN-1:0] if_instruction;
	logic if_valid;
	ctrl_t id_ctrl;

	fetch_if fif ();

	assign fif.freeze = freeze;
	assign fif.flush = flush;

	if_stage u_if_stage (
		.clk(clk), .rst_n(rst_n),
		.freeze(freeze), .branch_taken(branch_taken), .branch_addr(branch_addr),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_ack(wb_ack), .wb_dat_i(wb_dat_i),
		.pc(if_pc), .instruction(if_instruction), .valid(if_valid)
	);

	if_stage_reg u_if_stage_reg (
		.clk(clk), .rst_n(rst_n),
		.pc(if_pc), .instruction(if_instruction), .valid(if_valid),
		.ifr(fif.src)
	);

	id_stage u_id_stage (
		.clk(clk), .rst_n(rst_n), .ifd(fif.dst),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
		.id_pc(id_pc), .id_valid(id_valid), .id_ctrl(id_ctrl),
		.id_reg1(id_reg1), .id_reg2(id_reg2), .id_dest(id_dest),
		.id_signed_imm(id_signed_imm), .id_shift_operand(id_shift_operand)
	);

	// Control bundle flattened for the EX side
	assign id_exe_cmd = id_ctrl.exe_cmd;
	assign id_mem_read = id_ctrl.mem_read;
	assign id_mem_write = id_ctrl.mem_write;
	assign id_wb_en = id_ctrl.wb_en;
	assign id_immediate = id_ctrl.immediate;
	assign id_branch_taken = id_ctrl.branch_taken;
	assign id_status_write = id_ctrl.status_write;
endmodule

`default_nettype wire

//--- verilog/arm_pkg.sv
`default_nettype none

`include "arm_defs.svh"

package arm_pkg;

	// Data processing and load/store layout
	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] cls;
		logic imm;
		logic [3:0] opcode;
		logic s;
		logic [`REG_ADDRESS_LEN-1:0] rn;
		logic [`REG_ADDRESS_LEN-1:0] rd;
		logic [`SHIFT_OPERAND_LEN-1:0] shift_operand;
	} dp_view_t;

	// Branch layout, bits 27:25 are 101
	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] cls;
		logic fixed_one;
		logic link;
		logic [`SIGNED_IMMEDIATE_LEN-1:0] offset;
	} br_view_t;

	typedef union packed {
		dp_view_t dp;
		br_view_t br;
	} instr_word_t;

	typedef enum logic [`EXECUTE_COMMAND_LEN-1:0] {
		EXE_NOP = 4'b0000,
		EXE_MOV = 4'b0001,
		EXE_ADD = 4'b0010,
		EXE_ADC = 4'b0011,
		EXE_SUB = 4'b0100,
		EXE_SBC = 4'b0101,
		EXE_AND = 4'b0110,
		EXE_ORR = 4'b0111,
		EXE_EOR = 4'b1000,
		EXE_MVN = 4'b1001
	} exe_cmd_t;

	// Address calculation for memory access runs on the adder
	localparam exe_cmd_t EXE_LDR = EXE_ADD;
	localparam exe_cmd_t EXE_STR = EXE_ADD;

	typedef struct packed {
		exe_cmd_t exe_cmd;
		logic mem_read;
		logic mem_write;
		logic wb_en;
		logic immediate;
		logic branch_taken;
		logic status_write;
	} ctrl_t;

endpackage

`default_nettype wire

//--- verilog/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module control_unit (
	input  arm_pkg::instr_word_t instr,
	input  logic valid,
	output arm_pkg::ctrl_t ctrl,
	output logic two_src
);
	import arm_pkg::*;

	localparam logic [1:0] CLS_DP = 2'b00;
	localparam logic [1:0] CLS_MEM = 2'b01;
	localparam logic [1:0] CLS_BR = 2'b10;

	// ARM data processing opcodes
	localparam logic [3:0] OP_AND = 4'b0000;
	localparam logic [3:0] OP_EOR = 4'b0001;
	localparam logic [3:0] OP_SUB = 4'b0010;
	localparam logic [3:0] OP_ADD = 4'b0100;
	localparam logic [3:0] OP_ADC = 4'b0101;
	localparam logic [3:0] OP_SBC = 4'b0110;
	localparam logic [3:0] OP_TST = 4'b1000;
	localparam logic [3:0] OP_CMP = 4'b1010;
	localparam logic [3:0] OP_ORR = 4'b1100;
	localparam logic [3:0] OP_MOV = 4'b1101;
	localparam logic [3:0] OP_MVN = 4'b1111;

	always_comb begin
		ctrl = '{exe_cmd: EXE_NOP, default: 1'b0};
		two_src = 1'b0;
		if (valid) begin
			case (instr.dp.cls)
				CLS_DP: begin
					ctrl.wb_en = 1'b1;
					ctrl.status_write = instr.dp.s;
					ctrl.immediate = instr.dp.imm;
					two_src = !instr.dp.imm;
					case (instr.dp.opcode)
						OP_MOV: ctrl.exe_cmd = EXE_MOV;
						OP_MVN: ctrl.exe_cmd = EXE_MVN;
						OP_ADD: ctrl.exe_cmd = EXE_ADD;
						OP_ADC: ctrl.exe_cmd = EXE_ADC;
						OP_SUB: ctrl.exe_cmd = EXE_SUB;
						OP_SBC: ctrl.exe_cmd = EXE_SBC;
						OP_AND: ctrl.exe_cmd = EXE_AND;
						OP_ORR: ctrl.exe_cmd = EXE_ORR;
						OP_EOR: ctrl.exe_cmd = EXE_EOR;
						// Compare forms only update flags
						OP_CMP: begin
							ctrl.exe_cmd = EXE_SUB;
							ctrl.wb_en = 1'b0;
						end
						OP_TST: begin
							ctrl.exe_cmd = EXE_AND;
							ctrl.wb_en = 1'b0;
						end
						default: ctrl.wb_en = 1'b0;
					endcase
				end
				// S bit tells load from store
				CLS_MEM: begin
					ctrl.immediate = instr.dp.imm;
					if (instr.dp.s) begin
						ctrl.exe_cmd = EXE_LDR;
						ctrl.mem_read = 1'b1;
						ctrl.wb_en = 1'b1;
					end else begin
						ctrl.exe_cmd = EXE_STR;
						ctrl.mem_write = 1'b1;
						two_src = 1'b1;
					end
				end
				CLS_BR: ctrl.branch_taken = instr.br.fixed_one;
				default: ;
			endcase
		end
	end
endmodule

`default_nettype wire

//--- verilog/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

interface fetch_if;
	logic [`ADDRESS_LEN-1:0] pc;
	logic [`INSTRUCTION_LEN-1:0] instruction;
	logic valid;

	// Pipeline control from the top
	logic freeze;
	logic flush;

	modport src (output pc, instruction, valid, input freeze, flush);
	modport dst (input pc, instruction, valid, freeze, flush);
endinterface

`default_nettype wire

//--- verilog/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module id_stage (
	input  logic clk,
	input  logic rst_n,
	fetch_if.dst ifd,
	input  logic wb_en,
	input  logic [`REG_ADDRESS_LEN-1:0] wb_addr,
	input  logic [`REGISTER_LEN-1:0] wb_data,
	output logic [`ADDRESS_LEN-1:0] id_pc,
	output logic id_valid,
	output arm_pkg::ctrl_t id_ctrl,
	output logic [`REGISTER_LEN-1:0] id_reg1,
	output logic [`REGISTER_LEN-1:0] id_reg2,
	output logic [`REG_ADDRESS_LEN-1:0] id_dest,
	output logic [`SIGNED_IMMEDIATE_LEN-1:0] id_signed_imm,
	output logic [`SHIFT_OPERAND_LEN-1:0] id_shift_operand
);
	import arm_pkg::*;

	instr_word_t iw;
	ctrl_t ctrl;
	logic two_src;
	logic [`REG_ADDRESS_LEN-1:0] src2;
	logic [`REGISTER_LEN-1:0] reg1;
	logic [`REGISTER_LEN-1:0] reg2;

	assign iw = ifd.instruction;

	// Store data comes from Rd, register operands from Rm
	assign src2 = ctrl.mem_write ? iw.dp.rd : iw.dp.shift_operand[`REG_ADDRESS_LEN-1:0];

	control_unit u_control_unit (
		.instr(iw),
		.valid(ifd.valid),
		.ctrl(ctrl),
		.two_src(two_src)
	);

	register_file u_register_file (
		.clk(clk),
		.rst_n(rst_n),
		.src1(iw.dp.rn),
		.src2(src2),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.reg1(reg1),
		.reg2(reg2)
	);

	always_ff @(posedge clk) begin
		if (!rst_n || ifd.flush) begin
			id_valid <= 1'b0;
			id_ctrl <= '{exe_cmd: EXE_NOP, default: 1'b0};
		end else if (!ifd.freeze) begin
			id_valid <= ifd.valid;
			id_ctrl <= ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!ifd.freeze) begin
			id_pc <= ifd.pc;
			id_reg1 <= reg1;
			// Single-source forms carry no second operand
			id_reg2 <= two_src ? reg2 : '0;
			id_dest <= iw.dp.rd;
			id_signed_imm <= iw.br.offset;
			id_shift_operand <= iw.dp.shift_operand;
		end
	end
endmodule

`default_nettype wire

//--- verilog/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module if_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic freeze,
	input  logic branch_taken,
	input  logic [`ADDRESS_LEN-1:0] branch_addr,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`ADDRESS_LEN-1:0] wb_adr,
	input  logic wb_ack,
	input  logic [`INSTRUCTION_LEN-1:0] wb_dat_i,
	output logic [`ADDRESS_LEN-1:0] pc,
	output logic [`INSTRUCTION_LEN-1:0] instruction,
	output logic valid
);
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BUSY = 2'd1;
	localparam logic [1:0] ST_DISCARD = 2'd2;

	logic [1:0] state;
	logic [`ADDRESS_LEN-1:0] pc_reg;
	logic [`ADDRESS_LEN-1:0] redirect_pc;
	logic fetch_done;
	logic bus_wait;
	logic hold_valid;
	logic [`INSTRUCTION_LEN-1:0] hold_instr;

	// Read-only master with strobe tied to cycle
	assign wb_cyc = (state != ST_IDLE);
	assign wb_stb = wb_cyc;
	assign wb_we = 1'b0;
	assign wb_adr = pc_reg;

	assign fetch_done = (state == ST_BUSY) && wb_ack;
	assign bus_wait = wb_cyc && !wb_ack;

	// Word goes out on ack or later from the hold register after a freeze
	assign valid = !branch_taken && (fetch_done || hold_valid);
	assign instruction = hold_valid ? hold_instr : wb_dat_i;
	assign pc = fetch_done ? pc_reg + `ADDRESS_LEN'd4 : pc_reg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			pc_reg <= `RESET_PC;
			hold_valid <= 1'b0;
		end else begin
			// Address stays on the bus until the open cycle is acknowledged
			if (branch_taken && !bus_wait)
				pc_reg <= branch_addr;
			else if (state == ST_DISCARD && wb_ack)
				pc_reg <= redirect_pc;
			else if (fetch_done)
				pc_reg <= pc_reg + `ADDRESS_LEN'd4;

			case (state)
				ST_IDLE: if (!freeze) state <= ST_BUSY;
				// A redirect lets the bus cycle finish and drops its data
				ST_BUSY: begin
					if (wb_ack)
						state <= ST_IDLE;
					else if (branch_taken)
						state <= ST_DISCARD;
				end
				ST_DISCARD: if (wb_ack) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase

			if (branch_taken || !freeze)
				hold_valid <= 1'b0;
			else if (fetch_done)
				hold_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_done && freeze)
			hold_instr <= wb_dat_i;
		// Redirect target waits here until the discarded cycle ends
		if (branch_taken && bus_wait)
			redirect_pc <= branch_addr;
	end
endmodule

`default_nettype wire

//--- verilog/if_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module if_stage_reg (
	input  logic clk,
	input  logic rst_n,
	input  logic [`ADDRESS_LEN-1:0] pc,
	input  logic [`INSTRUCTION_LEN-1:0] instruction,
	input  logic valid,
	fetch_if.src ifr
);
	// Flush wins over freeze so a redirect always leaves a bubble
	always_ff @(posedge clk) begin
		if (!rst_n)
			ifr.valid <= 1'b0;
		else if (ifr.flush)
			ifr.valid <= 1'b0;
		else if (!ifr.freeze)
			ifr.valid <= valid;
	end

	always_ff @(posedge clk) begin
		if (!ifr.freeze) begin
			ifr.pc <= pc;
			ifr.instruction <= instruction;
		end
	end
endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_defs.svh"

module register_file (
	input  logic clk,
	input  logic rst_n,
	input  logic [`REG_ADDRESS_LEN-1:0] src1,
	input  logic [`REG_ADDRESS_LEN-1:0] src2,
	input  logic wb_en,
	input  logic [`REG_ADDRESS_LEN-1:0] wb_addr,
	input  logic [`REGISTER_LEN-1:0] wb_data,
	output logic [`REGISTER_LEN-1:0] reg1,
	output logic [`REGISTER_LEN-1:0] reg2
);
	localparam logic [`REG_ADDRESS_LEN-1:0] PC_REG = `REG_FILE_DEPTH;

	logic [`REGISTER_LEN-1:0] regs [0:`REG_FILE_DEPTH-1];

	// R15 is the PC and has no storage here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_FILE_DEPTH; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_addr != PC_REG) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Reads see the value from before a same-cycle write
	assign reg1 = (src1 == PC_REG) ? '0 : regs[src1];
	assign reg2 = (src2 == PC_REG) ? '0 : regs[src2];
endmodule

`default_nettype wire
